/* design/AsyncFifo.sv */
// Dual-clock FIFO with Gray pointers and a registered near-full alert
`timescale 1ns/1ps
`default_nettype none

`include "audio_tx_consts.svh"

module AsyncFifo #(
	parameter int Depth = 16,
	parameter int Width = 16
)(
	// Write side
	input  wire                        iSCLK,
	input  wire  [Width-1:0]           wd,
	input  wire                        we,
	output logic                       alert,
	output logic [$clog2(Depth):0]     level,
	// Read side
	input  wire                        iMCLK,
	output logic [Width-1:0]           rd,
	input  wire                        re,
	output logic                       empty,
	// Common
	input  wire                        rstN
);

	localparam int AddrW = $clog2(Depth);
	// Extra bit tells full from empty
	localparam int PtrW  = AddrW + 1;
	localparam logic [PtrW-1:0] AlertLevel = PtrW'(`AUDIO_FIFO_ALERT);

	logic [Width-1:0] mem [Depth];

	logic [PtrW-1:0] wBin;
	logic [PtrW-1:0] wBinNext;
	logic [PtrW-1:0] wGray;
	logic [PtrW-1:0] rGraySync1;
	logic [PtrW-1:0] rGraySync2;
	logic [PtrW-1:0] rBinW;
	logic [PtrW-1:0] levelNext;
	logic            full;
	logic            push;

	logic [PtrW-1:0] rBin;
	logic [PtrW-1:0] rBinNext;
	logic [PtrW-1:0] rGray;
	logic [PtrW-1:0] wGraySync1;
	logic [PtrW-1:0] wGraySync2;
	logic            pop;

	function automatic logic [PtrW-1:0] bin2gray(input logic [PtrW-1:0] b);
		return b ^ (b >> 1);
	endfunction

	function automatic logic [PtrW-1:0] gray2bin(input logic [PtrW-1:0] g);
		logic [PtrW-1:0] b;
		b[PtrW-1] = g[PtrW-1];
		for (int i = PtrW - 2; i >= 0; i--)
			b[i] = b[i+1] ^ g[i];
		return b;
	endfunction

	// ---------------------------------------------------------------------
	// Write side on iSCLK
	// ---------------------------------------------------------------------
	assign rBinW     = gray2bin(rGraySync2);
	assign level     = wBin - rBinW;
	assign full      = level == PtrW'(Depth);
	// Full drops the word rather than corrupting the head
	assign push      = we & ~full;
	assign wBinNext  = wBin + PtrW'(push);
	assign levelNext = wBinNext - rBinW;

	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
		begin
			wBin       <= '0;
			wGray      <= '0;
			rGraySync1 <= '0;
			rGraySync2 <= '0;
			alert      <= 1'b0;
		end
		else
		begin
			wBin       <= wBinNext;
			wGray      <= bin2gray(wBinNext);
			rGraySync1 <= rGray;
			rGraySync2 <= rGraySync1;
			alert      <= levelNext >= AlertLevel;
		end
	end

	always_ff @(posedge iSCLK)
	begin
		if (push)
			mem[wBin[AddrW-1:0]] <= wd;
	end

	// ---------------------------------------------------------------------
	// Read side on iMCLK
	// ---------------------------------------------------------------------
	// Show-ahead, head word is on rd while not empty
	assign rd       = mem[rBin[AddrW-1:0]];
	assign empty    = rGray == wGraySync2;
	assign pop      = re & ~empty;
	assign rBinNext = rBin + PtrW'(pop);

	always_ff @(posedge iMCLK)
	begin
		if (!rstN)
		begin
			rBin       <= '0;
			rGray      <= '0;
			wGraySync1 <= '0;
			wGraySync2 <= '0;
		end
		else
		begin
			rBin       <= rBinNext;
			rGray      <= bin2gray(rBinNext);
			wGraySync1 <= wGray;
			wGraySync2 <= wGraySync1;
		end
	end

endmodule

`default_nettype wire

/* design/AudioMixer.sv */
// Two-voice mixer with per-voice gain, saturating sum and registered FIFO write
`timescale 1ns/1ps
`default_nettype none

`include "audio_tx_consts.svh"

module AudioMixer (
	input  wire                               iSCLK,
	input  wire                               rstN,
	input  wire  audio_tx_pkg::audioCtrl_t    ctrl,
	input  wire  audio_tx_pkg::voicePair_t    streamDq,
	input  wire  [1:0]                        streamVd,
	output audio_tx_pkg::sample_t             mixData,
	output logic                              mixWe
);

	import audio_tx_pkg::*;

	localparam int SampleW   = `AUDIO_SAMPLE_W;
	localparam int GainW     = `AUDIO_GAIN_W;
	// Signed sample times gain with a zero sign bit
	localparam int ProdW     = SampleW + GainW + 1;
	localparam int SumW      = ProdW + 1;
	localparam int GainShift = GainW - 1;
	localparam logic signed [SumW-1:0] SatMax = SumW'((2 ** (SampleW - 1)) - 1);
	localparam logic signed [SumW-1:0] SatMin = SumW'(-(2 ** (SampleW - 1)));

	sample_t                 voice0;
	sample_t                 voice1;
	logic signed [ProdW-1:0] prod0;
	logic signed [ProdW-1:0] prod1;
	logic signed [SumW-1:0]  sum;
	sample_t                 satSum;

	// ---------------------------------------------------------------------
	// Gain and sum
	// ---------------------------------------------------------------------
	// Invalid voice counts as silence
	assign voice0 = streamVd[0] ? streamDq.voice0 : '0;
	assign voice1 = streamVd[1] ? streamDq.voice1 : '0;

	assign prod0 = voice0 * $signed({1'b0, ctrl.gain0});
	assign prod1 = voice1 * $signed({1'b0, ctrl.gain1});

	// Arithmetic shift keeps the sign, 128 maps back to unity
	assign sum = (prod0 >>> GainShift) + (prod1 >>> GainShift);

	// Clip to the sample range
	always_comb
	begin
		if (sum > SatMax)
			satSum = SatMax[SampleW-1:0];
		else if (sum < SatMin)
			satSum = SatMin[SampleW-1:0];
		else
			satSum = sum[SampleW-1:0];
	end

	// ---------------------------------------------------------------------
	// FIFO write, one cycle after the valid input
	// ---------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
			mixWe <= 1'b0;
		else
			mixWe <= ctrl.enable & (|streamVd);
	end

	always_ff @(posedge iSCLK)
	begin
		mixData <= satSum;
	end

endmodule

`default_nettype wire

/* design/AudioTxBlock.sv */
// Audio output path top with register slave, mixer, dual-clock FIFO and I2S encoder
`timescale 1ns/1ps
`default_nettype none

`include "audio_tx_consts.svh"

module AudioTxBlock (
	// Clocks and reset
	input  wire                          iSCLK,
	input  wire                          iMCLK,
	input  wire                          rstN,
	// Register bus
	input  wire  audio_tx_pkg::wbReq_t   wbReq,
	output audio_tx_pkg::wbRsp_t         wbRsp,
	// Sample stream
	input  wire  audio_tx_pkg::voicePair_t streamDq,
	input  wire  [1:0]                   streamVd,
	output logic [1:0]                   streamRdy,
	// I2S DAC
	output logic                         i2sBclk,
	output logic                         i2sLrclk,
	output logic                         i2sSdata
);

	import audio_tx_pkg::*;

	localparam int LevelW = $clog2(`AUDIO_FIFO_DEPTH) + 1;

	audioCtrl_t        ctrl;
	sample_t           mixData;
	logic              mixWe;
	logic              fifoAlert;
	logic [LevelW-1:0] fifoLevel;
	sample_t           fifoRd;
	logic              fifoRe;
	logic              fifoEmpty;
	logic              underrunToggle;

	// ---------------------------------------------------------------------
	// Registers
	// ---------------------------------------------------------------------
	AudioTxCsr u_AudioTxCsr (
		.iSCLK(iSCLK),   .rstN(rstN),
		.wbReq(wbReq),   .wbRsp(wbRsp),
		.ctrl(ctrl),     .fifoLevel(fifoLevel),
		.underrunToggle(underrunToggle)
	);

	// ---------------------------------------------------------------------
	// Mixer and FIFO, system clock side
	// ---------------------------------------------------------------------
	// Alert leaves headroom for words already in flight
	assign streamRdy = {2{ctrl.enable & ~fifoAlert}};

	AudioMixer u_AudioMixer (
		.iSCLK(iSCLK),       .rstN(rstN),
		.ctrl(ctrl),
		.streamDq(streamDq), .streamVd(streamVd),
		.mixData(mixData),   .mixWe(mixWe)
	);

	AsyncFifo #(
		.Depth(`AUDIO_FIFO_DEPTH),
		.Width(`AUDIO_SAMPLE_W)
	) u_AsyncFifo (
		.iSCLK(iSCLK),      .wd(mixData),    .we(mixWe),
		.alert(fifoAlert),  .level(fifoLevel),
		.iMCLK(iMCLK),      .rd(fifoRd),     .re(fifoRe),
		.empty(fifoEmpty),  .rstN(rstN)
	);

	// ---------------------------------------------------------------------
	// I2S encoder, audio clock side
	// ---------------------------------------------------------------------
	AudioTxI2S u_AudioTxI2S (
		.iMCLK(iMCLK),    .rstN(rstN),
		.rd(fifoRd),      .empty(fifoEmpty), .re(fifoRe),
		.bclk(i2sBclk),   .lrclk(i2sLrclk),  .sdata(i2sSdata),
		.underrunToggle(underrunToggle)
	);

endmodule

`default_nettype wire

/* design/AudioTxCsr.sv */
// Wishbone register slave for audio control, voice gains and underrun status
`timescale 1ns/1ps
`default_nettype none

`include "audio_tx_consts.svh"

module AudioTxCsr (
	input  wire                                 iSCLK,
	input  wire                                 rstN,
	input  wire  audio_tx_pkg::wbReq_t          wbReq,
	output audio_tx_pkg::wbRsp_t                wbRsp,
	output audio_tx_pkg::audioCtrl_t            ctrl,
	input  wire  [$clog2(`AUDIO_FIFO_DEPTH):0]  fifoLevel,
	input  wire                                 underrunToggle
);

	localparam int GainW  = `AUDIO_GAIN_W;
	localparam int LevelW = $clog2(`AUDIO_FIFO_DEPTH) + 1;
	// Word select from byte address bits 3:2
	localparam logic [1:0] SelCtrl   = 2'd0;
	localparam logic [1:0] SelGain0  = 2'd1;
	localparam logic [1:0] SelGain1  = 2'd2;
	localparam logic [1:0] SelStatus = 2'd3;
	localparam logic [GainW-1:0] GainUnity = GainW'(1 << (GainW - 1));

	logic                 ackQ;
	logic [`WB_DAT_W-1:0] datQ;
	logic [`WB_DAT_W-1:0] rdData;
	logic                 access;
	logic                 wrEn;
	logic [1:0]           regSel;
	logic                 underrunFlag;
	logic [2:0]           undSync;
	logic                 underrunEvent;

	// ---------------------------------------------------------------------
	// Bus handshake
	// ---------------------------------------------------------------------
	// New access only when no ack is pending, so ack lasts one cycle
	assign access = wbReq.cyc & wbReq.stb & ~ackQ;
	assign wrEn   = access & wbReq.we;
	assign regSel = wbReq.adr[3:2];

	assign wbRsp.ack = ackQ;
	assign wbRsp.dat = datQ;

	// Read mux
	always_comb
	begin
		rdData = '0;
		case (regSel)
			SelCtrl:   rdData[0] = ctrl.enable;
			SelGain0:  rdData[GainW-1:0] = ctrl.gain0;
			SelGain1:  rdData[GainW-1:0] = ctrl.gain1;
			SelStatus:
			begin
				rdData[0]           = underrunFlag;
				rdData[8 +: LevelW] = fifoLevel;
			end
			default:   rdData = '0;
		endcase
	end

	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
			ackQ <= 1'b0;
		else
			ackQ <= access;
	end

	// Read data lands with the ack
	always_ff @(posedge iSCLK)
	begin
		if (access)
			datQ <= rdData;
	end

	// ---------------------------------------------------------------------
	// Control registers and sticky underrun
	// ---------------------------------------------------------------------
	// Toggle from iMCLK, two sync stages plus one for edge detect
	assign underrunEvent = undSync[2] ^ undSync[1];

	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
		begin
			ctrl.enable  <= 1'b0;
			ctrl.gain0   <= GainUnity;
			ctrl.gain1   <= GainUnity;
			underrunFlag <= 1'b0;
			undSync      <= '0;
		end
		else
		begin
			undSync <= {undSync[1:0], underrunToggle};
			if (wrEn && regSel == SelCtrl)
				ctrl.enable <= wbReq.dat[0];
			if (wrEn && regSel == SelGain0)
				ctrl.gain0 <= wbReq.dat[GainW-1:0];
			if (wrEn && regSel == SelGain1)
				ctrl.gain1 <= wbReq.dat[GainW-1:0];
			// New underrun wins over a clear in the same cycle
			if (underrunEvent)
				underrunFlag <= 1'b1;
			else if (wrEn && regSel == SelStatus)
				underrunFlag <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* design/AudioTxI2S.sv */
// I2S encoder that derives BCLK and LRCLK from iMCLK and sends one sample per frame
`timescale 1ns/1ps
`default_nettype none

`include "audio_tx_consts.svh"

module AudioTxI2S (
	input  wire                         iMCLK,
	input  wire                         rstN,
	// FIFO read port
	input  wire  audio_tx_pkg::sample_t rd,
	input  wire                         empty,
	output logic                        re,
	// Serial output
	output logic                        bclk,
	output logic                        lrclk,
	output logic                        sdata,
	output logic                        underrunToggle
);

	import audio_tx_pkg::*;

	localparam int Div       = `AUDIO_BCLK_DIV;
	localparam int SlotBits  = `AUDIO_SLOT_BITS;
	localparam int FrameBits = 2 * SlotBits;
	localparam int SampleW   = `AUDIO_SAMPLE_W;
	localparam int PhaseW    = $clog2(Div);
	localparam int IdxW      = $clog2(FrameBits);
	localparam int SlotW     = $clog2(SlotBits);

	logic [PhaseW-1:0] phase;
	logic [IdxW-1:0]   bitIdx;
	logic [IdxW-1:0]   nextIdx;
	logic [SlotW-1:0]  slotPos;
	logic              bclkRise;
	logic              bclkFall;
	logic              frameEnd;
	logic              nextBit;
	sample_t           sample;

	// ---------------------------------------------------------------------
	// Bit clock timing
	// ---------------------------------------------------------------------
	// BCLK low for the first half of each period
	assign bclkRise = phase == PhaseW'(Div / 2 - 1);
	assign bclkFall = phase == PhaseW'(Div - 1);
	// Last iMCLK cycle of the frame
	assign frameEnd = bclkFall && (bitIdx == IdxW'(FrameBits - 1));
	assign re       = frameEnd & ~empty;

	assign nextIdx = bitIdx + IdxW'(1);
	assign slotPos = nextIdx[SlotW-1:0];

	// MSB one BCLK after the LRCLK edge, zero pad after the LSB
	always_comb
	begin
		nextBit = 1'b0;
		if (slotPos != '0 && int'(slotPos) <= SampleW)
			nextBit = sample[SampleW - int'(slotPos)];
	end

	// ---------------------------------------------------------------------
	// Counters, serial outputs and frame pop
	// ---------------------------------------------------------------------
	always_ff @(posedge iMCLK)
	begin
		if (!rstN)
		begin
			phase          <= '0;
			bitIdx         <= '0;
			bclk           <= 1'b0;
			lrclk          <= 1'b0;
			sdata          <= 1'b0;
			sample         <= '0;
			underrunToggle <= 1'b0;
		end
		else
		begin
			phase <= bclkFall ? '0 : phase + PhaseW'(1);
			if (bclkRise)
				bclk <= 1'b1;
			// Data and LRCLK move with the falling edge
			if (bclkFall)
			begin
				bclk   <= 1'b0;
				bitIdx <= nextIdx;
				lrclk  <= nextIdx[IdxW-1];
				sdata  <= nextBit;
			end
			// Empty FIFO gives a silent frame and flags underrun
			if (frameEnd)
			begin
				if (empty)
				begin
					sample         <= '0;
					underrunToggle <= ~underrunToggle;
				end
				else
					sample <= rd;
			end
		end
	end

endmodule

`default_nettype wire

/* design/audio_tx_consts.svh */
// Audio output path constants for widths, FIFO sizing and I2S clock ratios
`ifndef AUDIO_TX_CONSTS_SVH
`define AUDIO_TX_CONSTS_SVH

// ---------------------------------------------------------------------
// Sample and gain
// ---------------------------------------------------------------------
// Signed PCM sample width
`define AUDIO_SAMPLE_W 16
// Unsigned gain, 128 is unity
`define AUDIO_GAIN_W 8

// ---------------------------------------------------------------------
// FIFO and I2S timing
// ---------------------------------------------------------------------
`define AUDIO_FIFO_DEPTH 16
// Near-full alert threshold, leaves room for writes in flight
`define AUDIO_FIFO_ALERT 12
// iMCLK cycles per BCLK period
`define AUDIO_BCLK_DIV 4
// BCLK cycles per channel slot
`define AUDIO_SLOT_BITS 32

// Wishbone register bus
`define WB_ADR_W 4
`define WB_DAT_W 32

`endif

/* design/audio_tx_pkg.sv */
// Audio output path types for samples, stream words, control and Wishbone
`default_nettype none

`include "audio_tx_consts.svh"

package audio_tx_pkg;

	// One signed PCM sample
	typedef logic signed [`AUDIO_SAMPLE_W-1:0] sample_t;

	// Stream input word, voice 0 in the low half
	typedef struct packed {
		sample_t voice1;
		sample_t voice0;
	} voicePair_t;

	// Control register contents seen by the mixer
	typedef struct packed {
		logic                     enable;
		logic [`AUDIO_GAIN_W-1:0] gain0;
		logic [`AUDIO_GAIN_W-1:0] gain1;
	} audioCtrl_t;

	// Wishbone classic request from the bus master
	typedef struct packed {
		logic                 cyc;
		logic                 stb;
		logic                 we;
		logic [`WB_ADR_W-1:0] adr;
		logic [`WB_DAT_W-1:0] dat;
	} wbReq_t;

	// Wishbone response back to the master
	typedef struct packed {
		logic                 ack;
		logic [`WB_DAT_W-1:0] dat;
	} wbRsp_t;

endpackage

`default_nettype wire

/* dv/AudioTxTb.sv */
// Testbench for the audio output path with mixing model and I2S frame decoder
`timescale 1ns/1ps
`default_nettype none

`include "audio_tx_consts.svh"

module AudioTxTb;

	import audio_tx_pkg::*;

	localparam logic [3:0] RegCtrl   = 4'h0;
	localparam logic [3:0] RegGain0  = 4'h4;
	localparam logic [3:0] RegGain1  = 4'h8;
	localparam logic [3:0] RegStatus = 4'hC;
	localparam int GainShift = `AUDIO_GAIN_W - 1;
	localparam int SatMax    = (1 << (`AUDIO_SAMPLE_W - 1)) - 1;
	localparam int SatMin    = -(1 << (`AUDIO_SAMPLE_W - 1));
	// Roughly two frames of iSCLK cycles
	localparam int FrameWait = 400;

	logic       iSCLK;
	logic       iMCLK;
	logic       rstN;
	wbReq_t     wbReq;
	wbRsp_t     wbRsp;
	voicePair_t streamDq;
	logic [1:0] streamVd;
	logic [1:0] streamRdy;
	logic       i2sBclk;
	logic       i2sLrclk;
	logic       i2sSdata;

	integer  seed;
	int      gain0Model;
	int      gain1Model;
	sample_t expected[$];
	bit      pushedAny;
	bit      started;
	int      frameCount;
	// Decoder state
	logic        lrPrev;
	int          slotCnt;
	logic [31:0] slotShift;
	logic [31:0] leftSlot;

	AudioTxBlock u_AudioTxBlock (
		.iSCLK(iSCLK),         .iMCLK(iMCLK),         .rstN(rstN),
		.wbReq(wbReq),         .wbRsp(wbRsp),
		.streamDq(streamDq),   .streamVd(streamVd),   .streamRdy(streamRdy),
		.i2sBclk(i2sBclk),     .i2sLrclk(i2sLrclk),   .i2sSdata(i2sSdata)
	);

	// Unrelated clocks, rising edges never coincide
	always #10 iSCLK = ~iSCLK;
	always #7 iMCLK = ~iMCLK;

	// ---------------------------------------------------------------------
	// Reporting and model
	// ---------------------------------------------------------------------
	task automatic stopRun(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stopRun($sformatf("[FAIL] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp));
	endtask

	// Gain, arithmetic shift, sum, clip
	function automatic sample_t mixModel(input sample_t v0, input sample_t v1,
		input logic [1:0] mask, input int g0, input int g1);
		int p0;
		int p1;
		int sum;
		p0 = 0;
		p1 = 0;
		if (mask[0])
			p0 = (int'(v0) * g0) >>> GainShift;
		if (mask[1])
			p1 = (int'(v1) * g1) >>> GainShift;
		sum = p0 + p1;
		if (sum > SatMax)
			sum = SatMax;
		else if (sum < SatMin)
			sum = SatMin;
		return sample_t'(sum);
	endfunction

	// ---------------------------------------------------------------------
	// Wishbone master
	// ---------------------------------------------------------------------
	task automatic busCycle(input logic wr, input logic [3:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waitCnt;
		@(negedge iSCLK);
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we  = wr;
		wbReq.adr = adr;
		wbReq.dat = wdat;
		waitCnt = 0;
		do
		begin
			@(negedge iSCLK);
			waitCnt++;
		end
		while (!wbRsp.ack && waitCnt < 16);
		if (!wbRsp.ack)
			stopRun($sformatf("No Wishbone ack for address 0x%0h", adr));
		else
		begin
			rdat  = wbRsp.dat;
			wbReq = '0;
		end
	endtask

	task automatic busWrite(input logic [3:0] adr, input logic [31:0] wdat);
		logic [31:0] ignored;
		busCycle(1'b1, adr, wdat, ignored);
	endtask

	// ---------------------------------------------------------------------
	// Stream source
	// ---------------------------------------------------------------------
	// Random voices and valid masks, only while ready is high
	task automatic pushSamples(input int count, input bit fullScale);
		int          accepted;
		int          cycles;
		logic [31:0] r;
		sample_t     v0;
		sample_t     v1;
		logic [1:0]  mask;
		accepted = 0;
		cycles   = 0;
		while (accepted < count && cycles < count * FrameWait)
		begin
			@(negedge iSCLK);
			cycles++;
			r    = $random(seed);
			v0   = r[15:0];
			v1   = r[31:16];
			r    = $random(seed);
			mask = r[1:0];
			if (fullScale)
			begin
				v0 = r[2] ? 16'sh7fff : 16'sh8000;
				v1 = r[3] ? 16'sh7fff : 16'sh8000;
				if (mask == 2'b00)
					mask = 2'b11;
			end
			if (streamRdy == 2'b11)
			begin
				// First word must show up as a nonzero frame
				if (!pushedAny)
				begin
					v0   = 16'sh4000;
					mask = 2'b01;
				end
				if (mask != 2'b00)
				begin
					expected.push_back(mixModel(v0, v1, mask, gain0Model, gain1Model));
					accepted++;
					pushedAny = 1'b1;
				end
			end
			else
				mask = 2'b00;
			streamDq.voice0 = v0;
			streamDq.voice1 = v1;
			streamVd        = mask;
		end
		if (accepted < count)
			stopRun("Stream input was not accepted in time");
		else
		begin
			@(negedge iSCLK);
			streamVd = 2'b00;
		end
	endtask

	// Enable clear, ready must stay low while the FIFO empties
	task automatic waitDrain();
		int cycles;
		cycles = 0;
		while (expected.size() != 0 && cycles < 20 * FrameWait)
		begin
			@(negedge iSCLK);
			cycles++;
			check("streamRdy", streamRdy, 2'b00);
		end
		if (expected.size() != 0)
			stopRun("Expected samples never came out of the I2S encoder");
	endtask

	task automatic watchQuiet(input int frames);
		int startCount;
		int cycles;
		startCount = frameCount;
		cycles     = 0;
		while (frameCount < startCount + frames && cycles < frames * FrameWait)
		begin
			@(negedge iSCLK);
			cycles++;
			check("streamRdy", streamRdy, 2'b00);
		end
		if (frameCount < startCount + frames)
			stopRun("I2S frames stopped arriving");
	endtask

	// ---------------------------------------------------------------------
	// I2S decoder
	// ---------------------------------------------------------------------
	// Slot bit 31 is the LRCLK edge bit, 30:15 the sample, rest padding
	task automatic checkFrame(input logic [31:0] left, input logic [31:0] right);
		sample_t got;
		got = left[30:15];
		check("i2sSdata right slot", right, left);
		check("i2sSdata lead bit", left[31], 1'b0);
		check("i2sSdata pad bits", left[14:0], 15'd0);
		if (!started && got != 0)
			started = 1'b1;
		if (started && expected.size() > 0)
		begin
			check("i2sSdata sample", got, expected.pop_front());
		end
		else
			check("i2sSdata idle sample", got, 16'd0);
		frameCount++;
	endtask

	always @(posedge i2sBclk)
	begin
		if (i2sLrclk != lrPrev)
			slotCnt = 0;
		lrPrev    = i2sLrclk;
		slotShift = {slotShift[30:0], i2sSdata};
		slotCnt   = slotCnt + 1;
		if (slotCnt == `AUDIO_SLOT_BITS)
		begin
			if (!i2sLrclk)
				leftSlot = slotShift;
			else
				checkFrame(leftSlot, slotShift);
		end
	end

	// ---------------------------------------------------------------------
	// Test sequence
	// ---------------------------------------------------------------------
	initial
	begin
		logic [31:0] rdData;
		logic [31:0] r;
		int          polls;
		seed         = 51;
		iSCLK        = 1'b0;
		iMCLK        = 1'b0;
		rstN         = 1'b0;
		wbReq        = '0;
		streamDq     = '0;
		streamVd     = 2'b00;
		pushedAny    = 1'b0;
		started      = 1'b0;
		frameCount   = 0;
		lrPrev       = 1'b0;
		slotCnt      = 0;
		slotShift    = '0;
		leftSlot     = '0;
		repeat (8) @(negedge iSCLK);
		rstN = 1'b1;

		// Reset values, well before the first frame ends
		busCycle(1'b0, RegCtrl, 32'd0, rdData);
		check("CTRL", rdData, 32'h0);
		busCycle(1'b0, RegGain0, 32'd0, rdData);
		check("GAIN0", rdData, 32'h80);
		busCycle(1'b0, RegGain1, 32'd0, rdData);
		check("GAIN1", rdData, 32'h80);
		busCycle(1'b0, RegStatus, 32'd0, rdData);
		check("STATUS", rdData, 32'h0);
		check("streamRdy", streamRdy, 2'b00);

		// Random nonzero gains, then random traffic
		r = $random(seed);
		gain0Model = 1 + int'(r[7:0]) % 255;
		gain1Model = 1 + int'(r[15:8]) % 255;
		busWrite(RegGain0, 32'(gain0Model));
		busWrite(RegGain1, 32'(gain1Model));
		busWrite(RegCtrl, 32'h1);
		pushSamples(24, 1'b0);

		// Full scale at maximum gain saturates
		gain0Model = 255;
		gain1Model = 255;
		busWrite(RegGain0, 32'd255);
		busWrite(RegGain1, 32'd255);
		pushSamples(8, 1'b1);

		// Disabled path, queue drains then silence
		busWrite(RegCtrl, 32'h0);
		waitDrain();
		watchQuiet(2);

		// Fresh underrun sets the sticky flag, a write clears it
		busWrite(RegStatus, 32'h0);
		polls  = 0;
		rdData = '0;
		while (rdData[0] !== 1'b1 && polls < 300)
		begin
			busCycle(1'b0, RegStatus, 32'd0, rdData);
			polls++;
		end
		if (rdData[0] !== 1'b1)
			stopRun("STATUS underrun flag never set after the FIFO drained");
		else
		begin
			check("STATUS", rdData, 32'h1);
			busWrite(RegStatus, 32'h0);
			busCycle(1'b0, RegStatus, 32'd0, rdData);
			check("STATUS", rdData, 32'h0);
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* dv/AudioTx_properties.sv */
// Bound assertions on the Wishbone ack, FIFO write guard and I2S clock edges
`timescale 1ns/1ps
`default_nettype none

`include "audio_tx_consts.svh"

module AudioTxProperties (
	input wire                                iSCLK,
	input wire                                iMCLK,
	input wire                                rstN,
	input wire                                wbAck,
	input wire                                fifoWe,
	input wire [$clog2(`AUDIO_FIFO_DEPTH):0]  fifoLevel,
	input wire                                bclk,
	input wire                                lrclk
);

	localparam int LevelW = $clog2(`AUDIO_FIFO_DEPTH) + 1;

	// Single-cycle ack per access
	ackPulse: assert property (@(posedge iSCLK) disable iff (!rstN) wbAck |=> !wbAck)
		else $error("Wishbone ack held for more than one cycle");

	// Mixer never pushes into a full FIFO
	noWriteFull: assert property (@(posedge iSCLK) disable iff (!rstN)
		fifoWe |-> fifoLevel != LevelW'(`AUDIO_FIFO_DEPTH))
		else $error("FIFO written while full");

	// LRCLK moves together with a BCLK falling edge
	lrOnFall: assert property (@(posedge iMCLK) disable iff (!rstN)
		!$stable(lrclk) |-> $fell(bclk))
		else $error("LRCLK changed away from a BCLK falling edge");

endmodule

bind AudioTxBlock AudioTxProperties u_AudioTxProperties (
	.iSCLK(iSCLK),       .iMCLK(iMCLK),         .rstN(rstN),
	.wbAck(wbRsp.ack),   .fifoWe(mixWe),        .fifoLevel(fifoLevel),
	.bclk(i2sBclk),      .lrclk(i2sLrclk)
);

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the audio output path testbench with Verilator and run it.
# The exit status is the simulator's, so a failed check fails the script.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module AudioTxTb \
	-f verilog.f \
	--Mdir obj_dir \
	-o AudioTxSim
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit "$buildStatus"
fi

./obj_dir/AudioTxSim
simStatus=$?
if [ "$simStatus" -ne 0 ]; then
	echo "Simulation ended with status $simStatus"
	exit "$simStatus"
fi

echo "Simulation ended normally"
exit 0

/* verilog.f */
+incdir+design
design/audio_tx_pkg.sv
design/AudioTxCsr.sv
design/AudioMixer.sv
design/AsyncFifo.sv
design/AudioTxI2S.sv
design/AudioTxBlock.sv
dv/AudioTx_properties.sv
dv/AudioTxTb.sv
